// File: sim.f
+incdir+source
source/cpuPkg.sv
source/alu.sv
source/regFile.sv
source/fetchStage.sv
source/decodeStage.sv
source/execStage.sv
source/memWriteback.sv
source/cpuTop.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: cpu_pipeline

export_include_dirs:
  - source

sources:
  - files:
      - source/cpuPkg.sv
      - source/alu.sv
      - source/regFile.sv
      - source/fetchStage.sv
      - source/decodeStage.sv
      - source/execStage.sv
      - source/memWriteback.sv
      - source/cpuTop.sv
  - target: test
    files:
      - bench/cpuTb.sv

// File: bench/cpuTb.sv
/* cpu pipeline testbench */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb import cpuPkg::*; ();

  localparam int ProgLen     = 64;
  localparam int ResetCycles = 5;
  localparam int DrainCycles = 16;
  localparam int PipeDepth   = 5;
  localparam int CycleLimit  = ResetCycles + ProgLen + DrainCycles;
  localparam int MemWords    = 1024;
  localparam logic [`DATA_WIDTH-1:0] NopWord   = 32'hFC00_0000; // opcode 111111 decodes as a bubble
  localparam logic [`DATA_WIDTH-1:0] StoreBase = 32'h0000_0800; // store area above the load area

  logic                   clk;
  logic                   rstN;
  logic [`DATA_WIDTH-1:0] ibus;
  logic [`DATA_WIDTH-1:0] iaddr;
  logic [`DATA_WIDTH-1:0] memRdData;
  memReq_s                memReq;

  logic [`DATA_WIDTH-1:0] prog    [0:ProgLen-1];
  logic [`DATA_WIDTH-1:0] dataMem [0:MemWords-1];
  logic [`DATA_WIDTH-1:0] expAddr [$];  // expected stores in program order
  logic [`DATA_WIDTH-1:0] expData [$];
  logic [`DATA_WIDTH-1:0] expLoad [$];  // expected load addresses
  logic [15:0]            lfsr;
  logic [`DATA_WIDTH-1:0] expPc = '0;
  int                     cycleCount  = 0;
  int                     storeIdx    = 0;
  int                     loadIdx     = 0;
  int                     valueErrors = 0;
  int                     otherErrors = 0;

  cpuTop i_dut (
    .clk       (clk),
    .rstN      (rstN),
    .ibus      (ibus),
    .iaddr     (iaddr),
    .memReq    (memReq),
    .memRdData (memRdData)
  );

  // galois lfsr on x^16+x^14+x^13+x^11+1
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr   = lfsr >> 1;
    if (outBit) lfsr = lfsr ^ 16'hB400;
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], nextBit()}; // one step per bit
    return v;
  endfunction

  // preset contents that differ per word
  function automatic logic [31:0] fillWord(input logic [31:0] idx);
    return (idx * 32'h9E37_79B1) ^ {idx[15:0], ~idx[15:0]};
  endfunction

  function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // random program over r0..r7 with r31 as the store base
  function automatic void genProgram();
    int          storeNum;
    logic [2:0]  kind;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [5:0]  fn;
    logic [5:0]  op;
    storeNum = 0;
    prog[0]  = encI(`OP_ADDI, 5'd0, 5'd31, StoreBase[15:0]);
    for (int k = 1; k < ProgLen; k++) begin
      kind = 3'(randBits(3));
      rs   = 5'(randBits(3));
      rt   = 5'(randBits(3));
      rd   = 5'(randBits(3));
      if (kind >= 3'd6 && k < 4) kind = 3'd2; // r31 not yet visible
      case (kind)
        3'd0, 3'd1: begin
          case (randBits(3) % 5)
            0:       fn = `FN_ADD;
            1:       fn = `FN_SUB;
            2:       fn = `FN_XOR;
            3:       fn = `FN_AND;
            default: fn = `FN_OR;
          endcase
          prog[k] = encR(fn, rs, rt, rd);
        end
        3'd2, 3'd3: begin
          case (randBits(3) % 5)
            0:       op = `OP_ADDI;
            1:       op = `OP_SUBI;
            2:       op = `OP_XORI;
            3:       op = `OP_ANDI;
            default: op = `OP_ORI;
          endcase
          prog[k] = encI(op, rs, rt, 16'(randBits(16))); // negative imm half the time
        end
        3'd4: begin
          fn = randBits(1) ? `FN_SLT : `FN_SLE;
          if (randBits(1)) rt = rs; // equal operands
          prog[k] = encR(fn, rs, rt, rd);
        end
        3'd5:    prog[k] = encI(`OP_LW, 5'd0, rt, {7'd0, 7'(randBits(7)), 2'b00});
        default: begin
          prog[k]  = encI(`OP_SW, 5'd31, rt, 16'(storeNum * 4)); // fresh word each time
          storeNum = storeNum + 1;
        end
      endcase
    end
  endfunction

  // in-order model where a write shows up three instructions later
  function automatic void buildExpected();
    logic [`DATA_WIDTH-1:0] regs     [0:`REG_COUNT-1];
    logic [`DATA_WIDTH-1:0] refMem   [0:MemWords-1];
    logic                   pendEn   [0:2];
    logic [4:0]             pendAddr [0:2];
    logic [`DATA_WIDTH-1:0] pendData [0:2];
    logic [`DATA_WIDTH-1:0] w;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] immX;
    logic [`DATA_WIDTH-1:0] res;
    logic [`DATA_WIDTH-1:0] addr;
    logic                   en;
    logic [4:0]             dest;
    for (int i = 0; i < `REG_COUNT; i++) regs[i] = '0;
    for (int i = 0; i < MemWords; i++) refMem[i] = fillWord(i);
    for (int i = 0; i < 3; i++) pendEn[i] = 1'b0;
    for (int k = 0; k < ProgLen; k++) begin
      if (pendEn[0] && pendAddr[0] != 5'd0) regs[pendAddr[0]] = pendData[0]; // k-3 lands
      for (int j = 0; j < 2; j++) begin
        pendEn[j]   = pendEn[j+1];
        pendAddr[j] = pendAddr[j+1];
        pendData[j] = pendData[j+1];
      end
      w    = prog[k];
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      immX = {{16{w[15]}}, w[15:0]};
      addr = a + immX;
      en   = 1'b1;
      dest = w[20:16];
      res  = '0;
      case (w[31:26])
        `OP_RTYPE: begin
          dest = w[15:11];
          case (w[5:0])
            `FN_ADD: res = a + b;
            `FN_SUB: res = a - b;
            `FN_XOR: res = a ^ b;
            `FN_AND: res = a & b;
            `FN_OR:  res = a | b;
            `FN_SLT: res = {31'd0, a < b};  // unsigned
            `FN_SLE: res = {31'd0, a <= b};
            default: en = 1'b0;
          endcase
        end
        `OP_ADDI: res = a + immX;
        `OP_SUBI: res = a - immX;
        `OP_XORI: res = a ^ immX;
        `OP_ANDI: res = a & immX;
        `OP_ORI:  res = a | immX;
        `OP_LW: begin
          res = refMem[addr[11:2]];
          expLoad.push_back(addr);
        end
        `OP_SW: begin
          refMem[addr[11:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
          en = 1'b0;
        end
        default: en = 1'b0;
      endcase
      pendEn[2]   = en;
      pendAddr[2] = dest;
      pendData[2] = res;
    end
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  // instruction memory answers in the same cycle
  assign ibus      = (iaddr < ProgLen * 4) ? prog[iaddr[7:2]] : NopWord;
  // word addressed data memory
  assign memRdData = dataMem[memReq.addr[11:2]];

  always @(posedge clk) begin
    if (rstN && memReq.wrEn === 1'b1) dataMem[memReq.addr[11:2]] <= memReq.wrData;
  end

  // mid-cycle checks on settled DUT outputs
  always @(negedge clk) begin
    if (cycleCount > 0 && !rstN) begin
      assert (memReq.wrEn === 1'b0 && memReq.rdEn === 1'b0) else begin
        $display("ERROR memReq strobes in reset: rdEn %h wrEn %h", memReq.rdEn, memReq.wrEn);
        valueErrors++;
      end
      assert (iaddr === '0) else begin
        $display("ERROR iaddr in reset: got %h expected %h", iaddr, 32'h0);
        valueErrors++;
      end
    end else if (rstN) begin
      assert (iaddr === expPc) else begin
        $display("ERROR iaddr: got %h expected %h", iaddr, expPc);
        valueErrors++;
      end
      expPc = expPc + `PC_STEP;
      if (memReq.rdEn === 1'b1) begin
        if (loadIdx >= expLoad.size()) begin
          $display("unexpected extra load from address %h", memReq.addr);
          otherErrors++;
        end else begin
          assert (memReq.addr === expLoad[loadIdx]) else begin
            $display("ERROR memReq.addr load %0d: got %h expected %h",
                     loadIdx, memReq.addr, expLoad[loadIdx]);
            valueErrors++;
          end
          loadIdx++;
        end
      end
      if (memReq.wrEn === 1'b1) begin
        if (storeIdx >= expAddr.size()) begin
          $display("unexpected extra store to address %h", memReq.addr);
          otherErrors++;
        end else begin
          assert (memReq.addr === expAddr[storeIdx]) else begin
            $display("ERROR memReq.addr store %0d: got %h expected %h",
                     storeIdx, memReq.addr, expAddr[storeIdx]);
            valueErrors++;
          end
          assert (memReq.wrData === expData[storeIdx]) else begin
            $display("ERROR memReq.wrData store %0d: got %h expected %h",
                     storeIdx, memReq.wrData, expData[storeIdx]);
            valueErrors++;
          end
          storeIdx++;
        end
      end
    end
  end

  initial begin
    lfsr = 16'd46117;
    genProgram();
    buildExpected();
    for (int i = 0; i < MemWords; i++) dataMem[i] = fillWord(i);
    $display("program of %0d words, %0d stores and %0d loads expected",
             ProgLen, expAddr.size(), expLoad.size());
    // run until every store and load is seen and the pipe has drained
    while (cycleCount < CycleLimit &&
           !(storeIdx == expAddr.size() && loadIdx == expLoad.size() &&
             cycleCount >= ResetCycles + ProgLen + PipeDepth))
      @(posedge clk);
    if (storeIdx < expAddr.size() || loadIdx < expLoad.size()) begin
      $display("timed out after %0d cycles with %0d of %0d stores and %0d of %0d loads seen",
               cycleCount, storeIdx, expAddr.size(), loadIdx, expLoad.size());
      otherErrors++;
    end
    $display("stores checked %0d, loads checked %0d, value errors %0d, other errors %0d",
             storeIdx, loadIdx, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: source/cpuTop.sv
/* five stage cpu top */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] ibus,      // from instruction memory
  output logic [`DATA_WIDTH-1:0] iaddr,
  output memReq_s                memReq,    // to data memory
  input  logic [`DATA_WIDTH-1:0] memRdData
);

  instrWord_u                 fetchedWord;
  logic                       fetchValid;
  execCtrl_s                  execCtrl;
  wbCtrl_s                    memCtrl;
  logic                       wrEn;         // writeback into decode
  logic [`REG_ADDR_WIDTH-1:0] wrAddr;
  logic [`DATA_WIDTH-1:0]     wrData;

  // input side
  fetchStage i_fetch (
    .clk         (clk),
    .rstN        (rstN),
    .ibus        (ibus),
    .iaddr       (iaddr),
    .fetchedWord (fetchedWord),
    .fetchValid  (fetchValid)
  );

  // processing, decode with regfile then execute
  decodeStage i_decode (
    .clk         (clk),
    .rstN        (rstN),
    .fetchedWord (fetchedWord),
    .fetchValid  (fetchValid),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .execCtrl    (execCtrl)
  );

  execStage i_exec (
    .clk      (clk),
    .rstN     (rstN),
    .execCtrl (execCtrl),
    .memCtrl  (memCtrl),
    .memReq   (memReq)
  );

  // output side
  memWriteback i_memWb (
    .clk       (clk),
    .rstN      (rstN),
    .memCtrl   (memCtrl),
    .memRdData (memRdData),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData)
  );

endmodule

// File: source/memWriteback.sv
/* memory and writeback */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memWriteback import cpuPkg::*; (
  input  logic                       clk,
  input  logic                       rstN,
  input  wbCtrl_s                    memCtrl,
  input  logic [`DATA_WIDTH-1:0]     memRdData,
  output logic                       wrEn,
  output logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  output logic [`DATA_WIDTH-1:0]     wrData
);

  wbCtrl_s wbCtrl;
  logic    rdStrobe;

  assign rdStrobe = (memCtrl.memOp == memLoad); // same level as memReq.rdEn

  // mem/wb register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbCtrl.regWrite <= 1'b0;
      wbCtrl.memOp    <= memNone;
    end else begin
      wbCtrl.regWrite  <= memCtrl.regWrite;
      wbCtrl.destReg   <= memCtrl.destReg;
      wbCtrl.memOp     <= memCtrl.memOp;
      wbCtrl.aluResult <= memCtrl.aluResult;
      // load data takes the b slot
      wbCtrl.bValue    <= rdStrobe ? memRdData : memCtrl.bValue;
    end
  end

  // writeback, lands in the regfile at the end of this cycle
  assign wrEn   = wbCtrl.regWrite;
  assign wrAddr = wbCtrl.destReg;
  assign wrData = (wbCtrl.memOp == memLoad) ? wbCtrl.bValue : wbCtrl.aluResult;

endmodule

// File: source/execStage.sv
/* execute stage */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execStage import cpuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  execCtrl_s execCtrl,
  output wbCtrl_s   memCtrl,
  output memReq_s   memReq
);

  logic [`DATA_WIDTH-1:0] operandB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] exResult;
  logic                   carryOut;
  logic                   zero;
  logic                   setBit;

  assign operandB = execCtrl.useImm ? execCtrl.imm : execCtrl.b;

  alu i_alu (
    .a        (execCtrl.a),
    .b        (operandB),
    .aluOp    (execCtrl.aluOp),
    .result   (aluResult),
    .carryOut (carryOut),
    .zero     (zero)
  );

  // set-compares ride on the subtract flags
  always_comb begin
    case (execCtrl.setKind)
      setSlt:  setBit = !carryOut && !zero; // a < b
      setSle:  setBit = !carryOut || zero;  // a <= b
      default: setBit = 1'b0;
    endcase
  end

  assign exResult = (execCtrl.setKind == setNone) ? aluResult
                                                  : {{(`DATA_WIDTH-1){1'b0}}, setBit};

  // ex/mem register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memCtrl.regWrite <= 1'b0;
      memCtrl.memOp    <= memNone;
    end else begin
      memCtrl.regWrite  <= execCtrl.regWrite;
      memCtrl.destReg   <= execCtrl.destReg;
      memCtrl.memOp     <= execCtrl.memOp;
      memCtrl.aluResult <= exResult;   // also the data address
      memCtrl.bValue    <= execCtrl.b; // rt, store data
    end
  end

  // memory request straight off the registered bundle
  assign memReq.addr   = memCtrl.aluResult;
  assign memReq.wrData = memCtrl.bValue;
  assign memReq.rdEn   = (memCtrl.memOp == memLoad);
  assign memReq.wrEn   = (memCtrl.memOp == memStore);

endmodule

// File: source/decodeStage.sv
/* decode stage */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decodeStage import cpuPkg::*; (
  input  logic                       clk,
  input  logic                       rstN,
  input  instrWord_u                 fetchedWord,
  input  logic                       fetchValid,
  input  logic                       wrEn,     // writeback port
  input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  input  logic [`DATA_WIDTH-1:0]     wrData,
  output execCtrl_s                  execCtrl
);

  logic [`DATA_WIDTH-1:0] rdDataA;
  logic [`DATA_WIDTH-1:0] rdDataB;
  execCtrl_s              nextCtrl;
  logic                   known;   // opcode/funct recognised

  regFile i_regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (fetchedWord.i.rs),
    .rdAddrB (fetchedWord.i.rt),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData)
  );

  always_comb begin
    // defaults describe an i-format alu op
    nextCtrl          = '0;
    nextCtrl.aluOp    = aluAdd;
    nextCtrl.setKind  = setNone;
    nextCtrl.memOp    = memNone;
    nextCtrl.useImm   = 1'b1;
    nextCtrl.regWrite = 1'b1;
    nextCtrl.destReg  = fetchedWord.i.rt; // rt for i-format
    nextCtrl.a        = rdDataA;
    nextCtrl.b        = rdDataB;
    nextCtrl.imm      = {{(`DATA_WIDTH-`IMM_WIDTH){fetchedWord.i.imm[`IMM_WIDTH-1]}},
                         fetchedWord.i.imm};
    known             = 1'b1;
    case (fetchedWord.i.opcode)
      `OP_ADDI: nextCtrl.aluOp = aluAdd;
      `OP_SUBI: nextCtrl.aluOp = aluSub;
      `OP_XORI: nextCtrl.aluOp = aluXor;
      `OP_ANDI: nextCtrl.aluOp = aluAnd;
      `OP_ORI:  nextCtrl.aluOp = aluOr;
      `OP_LW:   nextCtrl.memOp = memLoad;  // address is rs + imm
      `OP_SW: begin
        nextCtrl.memOp    = memStore;
        nextCtrl.regWrite = 1'b0; // stores never write back
      end
      `OP_RTYPE: begin
        nextCtrl.useImm  = 1'b0;
        nextCtrl.destReg = fetchedWord.r.rd;
        case (fetchedWord.r.funct)
          `FN_ADD: nextCtrl.aluOp = aluAdd;
          `FN_SUB: nextCtrl.aluOp = aluSub;
          `FN_XOR: nextCtrl.aluOp = aluXor;
          `FN_AND: nextCtrl.aluOp = aluAnd;
          `FN_OR:  nextCtrl.aluOp = aluOr;
          `FN_SLT: begin
            nextCtrl.aluOp   = aluSub; // compare via a - b
            nextCtrl.setKind = setSlt;
          end
          `FN_SLE: begin
            nextCtrl.aluOp   = aluSub;
            nextCtrl.setKind = setSle;
          end
          default: known = 1'b0;
        endcase
      end
      default: known = 1'b0; // old branch codes land here too
    endcase
    // unknown or not yet fetched turns into a bubble
    if (!known || !fetchValid) begin
      nextCtrl.regWrite = 1'b0;
      nextCtrl.memOp    = memNone;
      nextCtrl.setKind  = setNone;
    end
  end

  // id/ex register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      execCtrl.regWrite <= 1'b0;
      execCtrl.memOp    <= memNone;
    end else begin
      execCtrl <= nextCtrl;
    end
  end

endmodule

// File: source/fetchStage.sv
/* fetch stage */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetchStage import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] ibus,        // instruction at iaddr, same cycle
  output logic [`DATA_WIDTH-1:0] iaddr,
  output instrWord_u             fetchedWord,
  output logic                   fetchValid
);

  logic [`DATA_WIDTH-1:0] pc;

  // pc sits at 0 through reset and the first cycle after
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc         <= '0;
      fetchValid <= 1'b0; // reset bubbles write nothing
    end else begin
      pc         <= pc + `PC_STEP;
      fetchValid <= 1'b1;
    end
  end

  // if/id register, payload only
  always_ff @(posedge clk) begin
    fetchedWord <= ibus;
  end

  assign iaddr = pc; // no branches, straight line fetch

endmodule

// File: source/regFile.sv
/* register file */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regFile (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [`REG_ADDR_WIDTH-1:0] rdAddrA,
  input  logic [`REG_ADDR_WIDTH-1:0] rdAddrB,
  output logic [`DATA_WIDTH-1:0]     rdDataA,
  output logic [`DATA_WIDTH-1:0]     rdDataB,
  input  logic                       wrEn,
  input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  input  logic [`DATA_WIDTH-1:0]     wrData
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT-1:1]; // no storage for r0

  // r0 reads zero, a same-cycle write shows through
  function automatic logic [`DATA_WIDTH-1:0] readPort(
    input logic [`REG_ADDR_WIDTH-1:0] addr
  );
    if (addr == '0) return '0;
    else if (wrEn && addr == wrAddr) return wrData;
    else return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < `REG_COUNT; i++) regs[i] <= '0;
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData; // writes to r0 dropped
    end
  end

  always_comb rdDataA = readPort(rdAddrA);
  always_comb rdDataB = readPort(rdAddrB);

endmodule

// File: source/alu.sv
/* alu */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu import cpuPkg::*; (
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  input  aluOp_e                 aluOp,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   carryOut,
  output logic                   zero
);

  logic                   carryIn;
  logic [`DATA_WIDTH-1:0] addend;
  logic [`DATA_WIDTH:0]   sum;   // one extra bit for carry

  // subtract is a + ~b + 1
  assign carryIn = (aluOp == aluSub);
  assign addend  = carryIn ? ~b : b;
  assign sum     = {1'b0, a} + {1'b0, addend} + {{`DATA_WIDTH{1'b0}}, carryIn};

  always_comb begin
    case (aluOp)
      aluAdd,
      aluSub:  result = sum[`DATA_WIDTH-1:0];
      aluXor:  result = a ^ b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      default: result = '0;
    endcase
  end

  assign carryOut = sum[`DATA_WIDTH]; // on sub, high means a >= b unsigned
  assign zero     = (result == '0);

endmodule

// File: source/cpuPkg.sv
/* cpu shared types */
`include "cpu_defs.svh"

package cpuPkg;

  // r-format view of an instruction word
  typedef struct packed {
    logic [5:0]                 opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [4:0]                 shamt; // unused by this core
    logic [5:0]                 funct;
  } rFormat_s;

  // i-format view, same word
  typedef struct packed {
    logic [5:0]                 opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`IMM_WIDTH-1:0]      imm;
  } iFormat_s;

  // decode looks at both views of one fetched word
  typedef union packed {
    rFormat_s r;
    iFormat_s i;
  } instrWord_u;

  typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluAnd, aluOr} aluOp_e;
  typedef enum logic [1:0] {setNone, setSlt, setSle} setKind_e;
  typedef enum logic [1:0] {memNone, memLoad, memStore} memOp_e;

  // decode -> execute
  typedef struct packed {
    aluOp_e                     aluOp;
    setKind_e                   setKind;
    memOp_e                     memOp;
    logic                       useImm;   // imm replaces b at the alu
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    logic [`DATA_WIDTH-1:0]     a;
    logic [`DATA_WIDTH-1:0]     b;        // also store data
    logic [`DATA_WIDTH-1:0]     imm;      // already sign extended
  } execCtrl_s;

  // request side of the data memory
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wrData;
    logic                   rdEn;
    logic                   wrEn;
  } memReq_s;

  // execute -> memory -> writeback
  typedef struct packed {
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
    memOp_e                     memOp;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic [`DATA_WIDTH-1:0]     bValue; // store data, load data after mem
  } wbCtrl_s;

endpackage

// File: source/cpu_defs.svh
/* cpu widths and codes */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_WIDTH      32 // datapath word
`define REG_COUNT       32 // incl. hardwired r0
`define REG_ADDR_WIDTH  5
`define IMM_WIDTH       16 // i-format immediate field
`define PC_STEP         4  // byte address step per fetch

// opcodes, bits 31:26
`define OP_RTYPE  6'b000000
`define OP_ADDI   6'b000011
`define OP_SUBI   6'b000010
`define OP_XORI   6'b000001
`define OP_ANDI   6'b001111
`define OP_ORI    6'b001100
`define OP_LW     6'b011110
`define OP_SW     6'b011111

// r-format function codes, bits 5:0
`define FN_ADD    6'b000011
`define FN_SUB    6'b000010
`define FN_XOR    6'b000001
`define FN_AND    6'b000111
`define FN_OR     6'b000100
`define FN_SLT    6'b110110 // unsigned set-less-than
`define FN_SLE    6'b110111 // unsigned set-less-or-equal

`endif
